// File: trap_mon_pkg.sv
`default_nettype none

package trap_mon_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Exception classes
  ////////////////////////////////////////////////////////////////////////////

  // The class index doubles as the report priority, lowest value goes first
  typedef enum logic [2:0] {
    CLS_INSTR_MPU = 3'd0,
    CLS_INSTR_BUS = 3'd1,
    CLS_ILLEGAL   = 3'd2,
    CLS_ECALL     = 3'd3,
    CLS_EBREAK    = 3'd4
  } exc_class_e;

  // Sizes every per-class flag vector and pc array
  localparam int NUM_CLASSES = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Cause codes and bus widths
  ////////////////////////////////////////////////////////////////////////////

  // Width of the exception code field the core saves into mcause
  localparam int CAUSE_W = 11;

  // Synchronous exception codes this monitor knows about
  localparam logic [CAUSE_W-1:0] CAUSE_INSTR_FAULT     = 11'd1;
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL         = 11'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_BREAKPOINT      = 11'd3;
  localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M         = 11'd11;
  localparam logic [CAUSE_W-1:0] CAUSE_INSTR_BUS_FAULT = 11'd24;

  // Atomic opcode width on the data bus, top bit marks an AMO or LR/SC
  localparam int ATOP_W = 6;

endpackage

`default_nettype wire

// File: exc_expect_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module exc_expect_tracker #(
  parameter int XLEN = 32
) (
  input  logic                                             clk,
  input  logic                                             rst_ni,
  input  logic                                             wb_valid_i,
  input  logic [XLEN-1:0]                                  wb_pc_i,
  input  logic                                             wb_illegal_i,
  input  logic                                             wb_ecall_i,
  input  logic                                             wb_ebreak_i,
  input  logic                                             wb_bus_err_i,
  input  logic                                             wb_mpu_err_i,
  input  logic                                             irq_ack_i,
  input  logic                                             debug_pending_i,
  input  logic                                             nmi_trap_i,
  input  logic                                             debug_mode_i,
  output logic [trap_mon_pkg::NUM_CLASSES-1:0]             exp_found_o,
  output logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0]   exp_pc_o
);

  // Interrupts, pending debug and NMIs win over the instruction in writeback
  logic                                 evt_blocked;
  logic [trap_mon_pkg::NUM_CLASSES-1:0] sel;

  assign evt_blocked = irq_ack_i || debug_pending_i || nmi_trap_i;

  // Several exception flags may be up together, only the highest priority one counts
  // Debug mode suppresses everything but ebreak, which then enters the debug handler
  always_comb begin
    sel = '0;
    if (wb_valid_i && !evt_blocked) begin
      if (wb_mpu_err_i) begin
        sel[trap_mon_pkg::CLS_INSTR_MPU] = !debug_mode_i;
      end else if (wb_bus_err_i) begin
        sel[trap_mon_pkg::CLS_INSTR_BUS] = !debug_mode_i;
      end else if (wb_illegal_i) begin
        sel[trap_mon_pkg::CLS_ILLEGAL] = !debug_mode_i;
      end else if (wb_ecall_i) begin
        sel[trap_mon_pkg::CLS_ECALL] = !debug_mode_i;
      end else if (wb_ebreak_i) begin
        sel[trap_mon_pkg::CLS_EBREAK] = 1'b1;
      end
    end
  end

  // Found bits are sticky until reset
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_o <= '0;
    end else begin
      exp_found_o <= exp_found_o | sel;
    end
  end

  // The pc is taken once, on the first hit of its class
  always_ff @(posedge clk) begin
    for (int i = 0; i < trap_mon_pkg::NUM_CLASSES; i++) begin
      if (sel[i] && !exp_found_o[i]) begin
        exp_pc_o[i] <= wb_pc_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: exc_cause_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module exc_cause_tracker #(
  parameter int XLEN = 32
) (
  input  logic                                             clk,
  input  logic                                             rst_ni,
  input  logic                                             csr_save_cause_i,
  input  logic                                             cause_irq_i,
  input  logic [trap_mon_pkg::CAUSE_W-1:0]                 cause_code_i,
  input  logic [XLEN-1:0]                                  mepc_next_i,
  output logic [trap_mon_pkg::NUM_CLASSES-1:0]             act_found_o,
  output logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0]   act_pc_o
);

  logic [trap_mon_pkg::NUM_CLASSES-1:0] sel;

  // Map a saved synchronous cause back onto its class
  // Interrupt causes share code values with exceptions, so they are filtered out first
  always_comb begin
    sel = '0;
    if (csr_save_cause_i && !cause_irq_i) begin
      case (cause_code_i)
        trap_mon_pkg::CAUSE_INSTR_FAULT:     sel[trap_mon_pkg::CLS_INSTR_MPU] = 1'b1;
        trap_mon_pkg::CAUSE_INSTR_BUS_FAULT: sel[trap_mon_pkg::CLS_INSTR_BUS] = 1'b1;
        trap_mon_pkg::CAUSE_ILLEGAL:         sel[trap_mon_pkg::CLS_ILLEGAL]   = 1'b1;
        trap_mon_pkg::CAUSE_ECALL_M:         sel[trap_mon_pkg::CLS_ECALL]     = 1'b1;
        trap_mon_pkg::CAUSE_BREAKPOINT:      sel[trap_mon_pkg::CLS_EBREAK]    = 1'b1;
        // Anything else is outside the checked set
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      act_found_o <= '0;
    end else begin
      act_found_o <= act_found_o | sel;
    end
  end

  // Only the first mepc written for each class is kept
  always_ff @(posedge clk) begin
    for (int i = 0; i < trap_mon_pkg::NUM_CLASSES; i++) begin
      if (sel[i] && !act_found_o[i]) begin
        act_pc_o[i] <= mepc_next_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: mepc_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module mepc_reporter #(
  parameter int XLEN = 32
) (
  input  logic                                            clk,
  input  logic                                            rst_ni,
  input  logic [trap_mon_pkg::NUM_CLASSES-1:0]            exp_found_i,
  input  logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0]  exp_pc_i,
  input  logic [trap_mon_pkg::NUM_CLASSES-1:0]            act_found_i,
  input  logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0]  act_pc_i,
  input  logic                                            rpt_ack_i,
  output logic                                            rpt_req_o,
  output trap_mon_pkg::exc_class_e                        rpt_class_o,
  output logic [XLEN-1:0]                                 rpt_expected_o,
  output logic [XLEN-1:0]                                 rpt_actual_o,
  output logic                                            rpt_match_o
);

  // Handshake states: idle, request raised, waiting for ack to drop
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_REQ     = 2'd1;
  localparam logic [1:0] ST_ACK_LOW = 2'd2;

  logic [1:0]                           state_q;
  logic [trap_mon_pkg::NUM_CLASSES-1:0] reported_q;
  logic [trap_mon_pkg::NUM_CLASSES-1:0] ready;
  logic [2:0]                           pick;

  // A class is ready once both sides have been seen and it has not gone out yet
  assign ready = exp_found_i & act_found_i & ~reported_q;

  // Scan downwards so the lowest ready class is the one left in pick
  always_comb begin
    pick = '0;
    for (int i = trap_mon_pkg::NUM_CLASSES - 1; i >= 0; i--) begin
      if (ready[i]) begin
        pick = i[2:0];
      end
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      reported_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|ready) begin
            state_q          <= ST_REQ;
            reported_q[pick] <= 1'b1;
          end
        end
        ST_REQ:     if (rpt_ack_i) state_q <= ST_ACK_LOW;
        ST_ACK_LOW: if (!rpt_ack_i) state_q <= ST_IDLE;
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  // Report data is only loaded from idle, so it stays put for the whole handshake
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && |ready) begin
      rpt_class_o    <= trap_mon_pkg::exc_class_e'(pick);
      rpt_expected_o <= exp_pc_i[pick];
      rpt_actual_o   <= act_pc_i[pick];
      rpt_match_o    <= (exp_pc_i[pick] == act_pc_i[pick]);
    end
  end

  assign rpt_req_o = (state_q == ST_REQ);

  // The receiver may sample any cycle before it acks, so nothing may move under it
  a_data_stable_until_ack :
    assert property (@(posedge clk) disable iff (!rst_ni)
                     rpt_req_o && !rpt_ack_i |=> rpt_req_o &&
                     $stable({rpt_class_o, rpt_expected_o, rpt_actual_o, rpt_match_o}))
      else $error("mepc_reporter: report changed while request pending");

endmodule

`default_nettype wire

// File: obi_outstanding_checker.sv
`timescale 1ns/1ps
`default_nettype none

module obi_outstanding_checker #(
  parameter int OBI_CNT_W = 2
) (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            data_req_i,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic                            data_we_i,
  input  logic [1:0]                      data_memtype_i,
  input  logic [trap_mon_pkg::ATOP_W-1:0] data_atop_i,
  output logic [OBI_CNT_W-1:0]            outstanding_o,
  output logic                            atop_order_err_o,
  output logic                            load_buf_err_o
);

  logic count_up;
  logic count_down;
  logic atop_req;
  logic buf_load;

  // Address phase ends on grant, response phase ends on rvalid
  assign count_up   = data_req_i && data_gnt_i;
  assign count_down = data_rvalid_i;

  // Atomics must wait until every earlier transaction has its response
  assign atop_req = data_req_i && data_atop_i[trap_mon_pkg::ATOP_W-1] && (outstanding_o != '0);
  // memtype bit 0 is the bufferable attribute, which a load must never carry
  assign buf_load = data_req_i && !data_we_i && data_memtype_i[0];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_o    <= '0;
      atop_order_err_o <= 1'b0;
      load_buf_err_o   <= 1'b0;
    end else begin
      // A grant and a response in the same cycle cancel out
      if (count_up && !count_down) begin
        outstanding_o <= outstanding_o + 1'b1;
      end else if (count_down && !count_up) begin
        outstanding_o <= outstanding_o - 1'b1;
      end
      // Both flags are sticky
      if (atop_req) atop_order_err_o <= 1'b1;
      if (buf_load) load_buf_err_o <= 1'b1;
    end
  end

  // A response with nothing in flight means the counter has lost track of the bus
  a_no_rvalid_when_idle :
    assert property (@(posedge clk) disable iff (!rst_ni)
                     data_rvalid_i |-> (outstanding_o != '0))
      else $error("obi_outstanding_checker: rvalid with no outstanding transaction");

endmodule

`default_nettype wire

// File: step_issue_checker.sv
`timescale 1ns/1ps
`default_nettype none

module step_issue_checker #(
  parameter int STEP_CNT_W = 4
) (
  input  logic clk,
  input  logic rst_ni,
  input  logic step_i,
  input  logic debug_mode_i,
  input  logic debug_taken_i,
  input  logic if_valid_i,
  input  logic id_ready_i,
  input  logic first_op_if_i,
  input  logic id_valid_i,
  input  logic ex_ready_i,
  input  logic first_op_id_i,
  input  logic haltreq_cause_i,
  input  logic irq_ack_i,
  input  logic nmi_pending_i,
  output logic step_err_o
);

  logic [STEP_CNT_W-1:0] cnt_if_q;
  logic [STEP_CNT_W-1:0] cnt_id_q;
  logic                  irq_ack_q;
  logic                  nmi_q;
  logic                  zero_ok;
  logic                  if_ok;
  logic                  id_ok;

  // Zero issued is fine when a halt request, interrupt or NMI preempted the step
  assign zero_ok = haltreq_cause_i || irq_ack_q || nmi_q;
  assign if_ok   = (cnt_if_q == STEP_CNT_W'(1)) || ((cnt_if_q == '0) && zero_ok);
  assign id_ok   = (cnt_id_q == STEP_CNT_W'(1)) || ((cnt_id_q == '0) && zero_ok);

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_if_q   <= '0;
      cnt_id_q   <= '0;
      irq_ack_q  <= 1'b0;
      nmi_q      <= 1'b0;
      step_err_o <= 1'b0;
    end else begin
      irq_ack_q <= irq_ack_i;
      nmi_q     <= nmi_pending_i;
      // Count first ops only, a split op counts once; saturate at the top
      if (debug_mode_i) begin
        cnt_if_q <= '0;
        cnt_id_q <= '0;
      end else begin
        if (if_valid_i && id_ready_i && first_op_if_i && (cnt_if_q != '1)) begin
          cnt_if_q <= cnt_if_q + 1'b1;
        end
        if (id_valid_i && ex_ready_i && first_op_id_i && (cnt_id_q != '1)) begin
          cnt_id_q <= cnt_id_q + 1'b1;
        end
      end
      // Judge the counts at the moment the step ends in debug entry
      if (debug_taken_i && step_i && !debug_mode_i && !(if_ok && id_ok)) begin
        step_err_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: trap_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module trap_monitor_top #(
  parameter int XLEN       = 32,
  parameter int OBI_CNT_W  = 2,
  parameter int STEP_CNT_W = 4
) (
  input  logic                            clk,
  input  logic                            rst_ni,
  // Writeback stage
  input  logic                            wb_valid_i,
  input  logic [XLEN-1:0]                 wb_pc_i,
  input  logic                            wb_illegal_i,
  input  logic                            wb_ecall_i,
  input  logic                            wb_ebreak_i,
  input  logic                            wb_bus_err_i,
  input  logic                            wb_mpu_err_i,
  input  logic                            irq_ack_i,
  input  logic                            debug_pending_i,
  input  logic                            nmi_trap_i,
  input  logic                            debug_mode_i,
  // CSR cause save
  input  logic                            csr_save_cause_i,
  input  logic                            cause_irq_i,
  input  logic [trap_mon_pkg::CAUSE_W-1:0] cause_code_i,
  input  logic [XLEN-1:0]                 mepc_next_i,
  // Report handshake
  input  logic                            rpt_ack_i,
  output logic                            rpt_req_o,
  output trap_mon_pkg::exc_class_e        rpt_class_o,
  output logic [XLEN-1:0]                 rpt_expected_o,
  output logic [XLEN-1:0]                 rpt_actual_o,
  output logic                            rpt_match_o,
  // Data bus
  input  logic                            data_req_i,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic                            data_we_i,
  input  logic [1:0]                      data_memtype_i,
  input  logic [trap_mon_pkg::ATOP_W-1:0] data_atop_i,
  output logic [OBI_CNT_W-1:0]            outstanding_o,
  output logic                            atop_order_err_o,
  output logic                            load_buf_err_o,
  // Single step
  input  logic                            step_i,
  input  logic                            debug_taken_i,
  input  logic                            if_valid_i,
  input  logic                            id_ready_i,
  input  logic                            first_op_if_i,
  input  logic                            id_valid_i,
  input  logic                            ex_ready_i,
  input  logic                            first_op_id_i,
  input  logic                            haltreq_cause_i,
  input  logic                            nmi_pending_i,
  output logic                            step_err_o
);

  //////////////////////////////////////////////////////////////////////////
  // Exception pc capture and reporting
  //////////////////////////////////////////////////////////////////////////

  logic [trap_mon_pkg::NUM_CLASSES-1:0]           exp_found;
  logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0] exp_pc;
  logic [trap_mon_pkg::NUM_CLASSES-1:0]           act_found;
  logic [trap_mon_pkg::NUM_CLASSES-1:0][XLEN-1:0] act_pc;

  exc_expect_tracker #(.XLEN(XLEN)) u_expect (
    .clk, .rst_ni, .wb_valid_i, .wb_pc_i, .wb_illegal_i, .wb_ecall_i, .wb_ebreak_i,
    .wb_bus_err_i, .wb_mpu_err_i, .irq_ack_i, .debug_pending_i, .nmi_trap_i,
    .debug_mode_i, .exp_found_o(exp_found), .exp_pc_o(exp_pc)
  );

  exc_cause_tracker #(.XLEN(XLEN)) u_cause (
    .clk, .rst_ni, .csr_save_cause_i, .cause_irq_i, .cause_code_i, .mepc_next_i,
    .act_found_o(act_found), .act_pc_o(act_pc)
  );

  mepc_reporter #(.XLEN(XLEN)) u_reporter (
    .clk, .rst_ni, .exp_found_i(exp_found), .exp_pc_i(exp_pc),
    .act_found_i(act_found), .act_pc_i(act_pc), .rpt_ack_i, .rpt_req_o,
    .rpt_class_o, .rpt_expected_o, .rpt_actual_o, .rpt_match_o
  );

  //////////////////////////////////////////////////////////////////////////
  // Bus and single-step checks
  //////////////////////////////////////////////////////////////////////////

  obi_outstanding_checker #(.OBI_CNT_W(OBI_CNT_W)) u_obi (
    .clk, .rst_ni, .data_req_i, .data_gnt_i, .data_rvalid_i, .data_we_i,
    .data_memtype_i, .data_atop_i, .outstanding_o, .atop_order_err_o, .load_buf_err_o
  );

  step_issue_checker #(.STEP_CNT_W(STEP_CNT_W)) u_step (
    .clk, .rst_ni, .step_i, .debug_mode_i, .debug_taken_i, .if_valid_i, .id_ready_i,
    .first_op_if_i, .id_valid_i, .ex_ready_i, .first_op_id_i, .haltreq_cause_i,
    .irq_ack_i, .nmi_pending_i, .step_err_o
  );

endmodule

`default_nettype wire

// File: tb_trap_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trap_monitor;

  logic clk = 1'b0;
  logic rst_ni;
  logic wb_valid_i, wb_illegal_i, wb_ecall_i, wb_ebreak_i, wb_bus_err_i, wb_mpu_err_i;
  logic irq_ack_i, debug_pending_i, nmi_trap_i, debug_mode_i;
  logic [31:0] wb_pc_i;
  logic [31:0] mepc_next_i;
  logic csr_save_cause_i, cause_irq_i;
  logic [trap_mon_pkg::CAUSE_W-1:0] cause_code_i;
  logic rpt_ack_i, rpt_req_o, rpt_match_o;
  trap_mon_pkg::exc_class_e rpt_class_o;
  logic [31:0] rpt_expected_o, rpt_actual_o;
  logic data_req_i, data_gnt_i, data_rvalid_i, data_we_i;
  logic [1:0] data_memtype_i;
  logic [trap_mon_pkg::ATOP_W-1:0] data_atop_i;
  logic [1:0] outstanding_o;
  logic atop_order_err_o, load_buf_err_o, step_err_o;
  logic step_i, debug_taken_i, if_valid_i, id_ready_i, first_op_if_i;
  logic id_valid_i, ex_ready_i, first_op_id_i, haltreq_cause_i, nmi_pending_i;

  // Expected reports in arrival order, and the state of the bus and step models
  logic [67:0] exp_q[$];
  logic [67:0] want;
  logic [67:0] held;
  logic        req_seen = 1'b0;
  logic [31:0] pc, pc2;
  int          model_out = 0;
  logic        model_atop = 1'b0;
  logic        model_buf = 1'b0;
  logic        model_step = 1'b0;

  trap_monitor_top #(.XLEN(32), .OBI_CNT_W(2), .STEP_CNT_W(4)) dut_i (.*);

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [67:0] got, input logic [67:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Report word laid out as {class, expected pc, actual pc, match}
  function automatic logic [67:0] ref_report(input logic [2:0] cls, input logic [31:0] wb_pc,
                                             input logic [31:0] mepc);
    return {cls, wb_pc, mepc, wb_pc == mepc};
  endfunction

  function automatic logic [10:0] code_of(input logic [2:0] cls);
    case (cls)
      3'd0:    return trap_mon_pkg::CAUSE_INSTR_FAULT;
      3'd1:    return trap_mon_pkg::CAUSE_INSTR_BUS_FAULT;
      3'd2:    return trap_mon_pkg::CAUSE_ILLEGAL;
      3'd3:    return trap_mon_pkg::CAUSE_ECALL_M;
      default: return trap_mon_pkg::CAUSE_BREAKPOINT;
    endcase
  endfunction

  function automatic logic [31:0] rand_pc();
    logic [31:0] r;
    r = $urandom();
    return {r[31:1], 1'b0};
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_ni <= 1'b0;
    repeat (8) @(posedge clk);
    rst_ni <= 1'b1;
  endtask

  // Flags are {ebreak, ecall, illegal, bus error, mpu error}, one cycle in writeback
  task automatic wb_event(input logic [31:0] wpc, input logic [4:0] flags, input logic irq,
                          input logic dbg_pend);
    @(posedge clk);
    wb_valid_i <= 1'b1;
    wb_pc_i <= wpc;
    {wb_ebreak_i, wb_ecall_i, wb_illegal_i, wb_bus_err_i, wb_mpu_err_i} <= flags;
    irq_ack_i <= irq;
    debug_pending_i <= dbg_pend;
    @(posedge clk);
    {wb_valid_i, wb_ebreak_i, wb_ecall_i, wb_illegal_i, wb_bus_err_i, wb_mpu_err_i} <= '0;
    {irq_ack_i, debug_pending_i} <= '0;
  endtask

  task automatic save_cause(input logic [10:0] code, input logic [31:0] mepc);
    @(posedge clk);
    csr_save_cause_i <= 1'b1;
    cause_code_i <= code;
    mepc_next_i <= mepc;
    @(posedge clk);
    csr_save_cause_i <= 1'b0;
  endtask

  // Acknowledge one report, holding ack low and then high for the given cycles
  task automatic ack_report(input int hold_hi, input int hold_lo);
    int n;
    n = 0;
    while (!rpt_req_o) begin
      @(negedge clk);
      n++;
      if (n > 20) abort_run("Timed out waiting for the report request to rise");
    end
    repeat (hold_hi) @(posedge clk);
    rpt_ack_i <= 1'b1;
    n = 0;
    while (rpt_req_o) begin
      @(negedge clk);
      n++;
      if (n > 10) abort_run("Timed out waiting for the report request to fall");
    end
    repeat (hold_lo + 1) @(posedge clk);
    rpt_ack_i <= 1'b0;
  endtask

  // One bus cycle followed by an idle cycle, checked against the counter model
  task automatic bus_cycle(input logic req, gnt, rvalid, we, input logic [1:0] mtype,
                           input logic [5:0] atop);
    @(posedge clk);
    {data_req_i, data_gnt_i, data_rvalid_i, data_we_i} <= {req, gnt, rvalid, we};
    data_memtype_i <= mtype;
    data_atop_i <= atop;
    if (req && atop[5] && model_out != 0) model_atop = 1'b1;
    if (req && !we && mtype[0]) model_buf = 1'b1;
    if (req && gnt && !rvalid) model_out++;
    else if (rvalid && !(req && gnt)) model_out--;
    @(posedge clk);
    {data_req_i, data_gnt_i, data_rvalid_i} <= '0;
    @(negedge clk);
    check_val("outstanding_o", 68'(outstanding_o), 68'(model_out));
    check_val("atop_order_err_o", 68'(atop_order_err_o), 68'(model_atop));
    check_val("load_buf_err_o", 68'(load_buf_err_o), 68'(model_buf));
  endtask

  task automatic drive_step(input logic dbg, input logic st, input logic taken,
                            input logic issue, input logic halt);
    @(posedge clk);
    {debug_mode_i, step_i, debug_taken_i, haltreq_cause_i} <= {dbg, st, taken, halt};
    {if_valid_i, id_ready_i, first_op_if_i} <= {3{issue}};
    {id_valid_i, ex_ready_i, first_op_id_i} <= {3{issue}};
  endtask

  // Debug mode clears the counters, then a step issues some instructions and ends in debug
  task automatic run_step(input int issued, input logic halt);
    drive_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < issued; i++) drive_step(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    drive_step(1'b0, 1'b1, 1'b1, 1'b0, halt);
    drive_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    if (!(issued == 1 || (issued == 0 && halt))) model_step = 1'b1;
    @(negedge clk);
    check_val("step_err_o", 68'(step_err_o), 68'(model_step));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Report checker, sampled on the falling edge where outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rpt_req_o && !req_seen) begin
      if (rpt_ack_i) abort_run("A new report request rose before acknowledge fell");
      if (exp_q.size() == 0) abort_run("A report arrived when none was expected");
      want = exp_q.pop_front();
      check_val("rpt_class_o", 68'(rpt_class_o), 68'(want[67:65]));
      check_val("rpt_expected_o", 68'(rpt_expected_o), 68'(want[64:33]));
      check_val("rpt_actual_o", 68'(rpt_actual_o), 68'(want[32:1]));
      check_val("rpt_match_o", 68'(rpt_match_o), 68'(want[0]));
      held = {rpt_class_o, rpt_expected_o, rpt_actual_o, rpt_match_o};
    end else if (rpt_req_o && !rpt_ack_i) begin
      // Back-pressure must leave every report field untouched
      check_val("rpt held data", {rpt_class_o, rpt_expected_o, rpt_actual_o, rpt_match_o}, held);
    end
    if (req_seen && !rpt_req_o && !rpt_ack_i) begin
      abort_run("The report request dropped before it was acknowledged");
    end
    req_seen = rpt_req_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h0b99b4d8));
    rst_ni = 1'b0;
    {wb_valid_i, wb_illegal_i, wb_ecall_i, wb_ebreak_i, wb_bus_err_i, wb_mpu_err_i} = '0;
    {irq_ack_i, debug_pending_i, nmi_trap_i, debug_mode_i, csr_save_cause_i, cause_irq_i} = '0;
    {wb_pc_i, mepc_next_i, cause_code_i, rpt_ack_i} = '0;
    {data_req_i, data_gnt_i, data_rvalid_i, data_we_i, data_memtype_i, data_atop_i} = '0;
    {step_i, debug_taken_i, if_valid_i, id_ready_i, first_op_if_i, id_valid_i} = '0;
    {ex_ready_i, first_op_id_i, haltreq_cause_i, nmi_pending_i} = '0;
    apply_reset();
    @(negedge clk);
    check_val("rpt_req_o", 68'(rpt_req_o), 68'd0);
    check_val("outstanding_o", 68'(outstanding_o), 68'd0);
    check_val("step_err_o", 68'(step_err_o), 68'd0);

    // Every class once with a matching mepc
    for (int c = 0; c < 5; c++) begin
      pc = rand_pc();
      wb_event(pc, 5'(1 << c), 1'b0, 1'b0);
      save_cause(code_of(3'(c)), pc);
      exp_q.push_back(ref_report(3'(c), pc, pc));
      ack_report($urandom_range(1, 4), $urandom_range(0, 3));
    end

    // Bus error wins over illegal, and the saved mepc differs
    apply_reset();
    pc = rand_pc();
    wb_event(pc, 5'b00110, 1'b0, 1'b0);
    save_cause(trap_mon_pkg::CAUSE_INSTR_BUS_FAULT, pc + 32'd4);
    exp_q.push_back(ref_report(trap_mon_pkg::CLS_INSTR_BUS, pc, pc + 32'd4));
    ack_report(2, 1);
    // Illegal under irq ack or pending debug is not captured, so no report may show yet
    wb_event(rand_pc(), 5'b00100, 1'b1, 1'b0);
    wb_event(rand_pc(), 5'b00100, 1'b0, 1'b1);
    pc = rand_pc();
    save_cause(trap_mon_pkg::CAUSE_ILLEGAL, pc);
    repeat (6) @(posedge clk);
    wb_event(pc, 5'b00100, 1'b0, 1'b0);
    exp_q.push_back(ref_report(trap_mon_pkg::CLS_ILLEGAL, pc, pc));
    ack_report(1, 0);
    // A second bus fault is already reported and stays silent
    pc = rand_pc();
    wb_event(pc, 5'b00010, 1'b0, 1'b0);
    save_cause(trap_mon_pkg::CAUSE_INSTR_BUS_FAULT, pc);
    repeat (6) @(posedge clk);

    // Long ack delay on ecall while ebreak becomes ready behind it
    pc = rand_pc();
    pc2 = rand_pc();
    wb_event(pc, 5'b01000, 1'b0, 1'b0);
    save_cause(trap_mon_pkg::CAUSE_ECALL_M, pc);
    exp_q.push_back(ref_report(trap_mon_pkg::CLS_ECALL, pc, pc));
    wb_event(pc2, 5'b10000, 1'b0, 1'b0);
    save_cause(trap_mon_pkg::CAUSE_BREAKPOINT, pc2);
    exp_q.push_back(ref_report(trap_mon_pkg::CLS_EBREAK, pc2, pc2));
    ack_report($urandom_range(20, 50), $urandom_range(2, 6));
    ack_report(1, 0);

    // Outstanding counter, then an atomic while a load is still in flight
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b1, 1'b1, 1'b1, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b1, 2'b00, 6'h20);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'b00, 6'h00);
    // A bufferable store is legal, a bufferable load is not
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b1, 2'b01, 6'h00);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'b00, 6'h00);
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, 2'b01, 6'h00);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 2'b00, 6'h00);

    // The error flag is sticky, so the legal step cases go first
    run_step(1, 1'b0);
    run_step(0, 1'b1);
    run_step(2, 1'b0);
    drive_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected reports never arrived", exp_q.size()));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: build.f
trap_mon_pkg.sv
exc_expect_tracker.sv
exc_cause_tracker.sv
mepc_reporter.sv
obi_outstanding_checker.sv
step_issue_checker.sv
trap_monitor_top.sv
tb_trap_monitor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_trap_monitor
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
